// ==== tb.f ====
source/captureDefsPkg.sv
source/uartDefsPkg.sv
source/pulseGateCounter.sv
source/captureSequencer.sv
source/sampleRam.sv
source/uartUploader.sv
source/pulseCaptureTop.sv
tests/uartFrameMonitor.sv
tests/pulseCaptureTb.sv

// ==== Makefile ====
# Verilator flow for the pulse capture logger.

TOOL     = verilator
FLAGS    = --timing --assert --timescale 1ns/1ns
TOP      = pulseCaptureTb
RTL_TOP  = pulseCaptureTop
FILELIST = tb.f
OBJDIR   = obj_dir
PASS_MSG = TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

# Static checks of the design alone and of the full testbench.
lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build, run, and pass only if the pass line shows up.
sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== tests/pulseCaptureTb.sv ====
`timescale 1ns/1ns

module pulseCaptureTb;
	import captureDefsPkg::*;
	import uartDefsPkg::*;

	localparam int DriveDelay    = 1;                            // Input skew after the edge.
	localparam int WordBytes     = 2 * SampleDepth;              // Bytes per upload.
	localparam int TimeoutCycles =
		(2 * SampleDepth * GatePeriod + 2 * WordBytes * FrameBits * BaudDiv) * 12 / 10;
	localparam int MaxWindows    = TimeoutCycles / GatePeriod + 2;

	logic                iClk = 1'b0;
	logic                iRst_N;
	logic                iPulse_i;
	logic                iCaptureStart_i;
	logic                oTxd_o;
	logic                oCaptureBusy_o;
	logic                oUploadBusy_o;
	logic                byteValid;
	logic [DataBits-1:0] rxByte;
	logic [DataBits-1:0] lowByte;
	countT               rxWord;
	integer              seed;
	int                  cyc = 0;                  // Clocks since reset release.
	int                  winCount [MaxWindows];    // Driven edges per window.
	int                  firstWin [4];             // First window of each capture.
	int                  acceptedCaptures = 0;
	int                  capturesSeen = 0;
	int                  rxTotal = 0;              // Bytes over the whole run.
	int                  byteIdx;
	int                  winIdx;
	int                  valueErrors = 0;
	int                  ruleErrors = 0;
	int                  frameErrors;
	logic                capBusyQ = 1'b0;

	always #5 iClk = ~iClk;                         // 10 ns clock.

	pulseCaptureTop pulseCaptureTop_i (
		.iClk            (iClk),
		.iRst_N          (iRst_N),
		.iPulse_i        (iPulse_i),
		.iCaptureStart_i (iCaptureStart_i),
		.oTxd_o          (oTxd_o),
		.oCaptureBusy_o  (oCaptureBusy_o),
		.oUploadBusy_o   (oUploadBusy_o)
	);

	uartFrameMonitor frameMonitor_i (
		.iClk           (iClk),
		.iRst_N         (iRst_N),
		.iTxd_i         (oTxd_o),
		.oByteValid_o   (byteValid),
		.oByte_o        (rxByte),
		.oFrameErrors_o (frameErrors)
	);

	task automatic logMismatch(input string sigName, input int expVal, input int actVal);
		valueErrors = valueErrors + 1;
		$display("ERR %0t %s expected %0d actual %0d", $time, sigName, expVal, actVal);
	endtask

	task automatic reportFault(input string what);
		ruleErrors = ruleErrors + 1;
		$display("At %0t: %s", $time, what);
	endtask

	// One-clock start strobe, window model noted when it should be taken.
	task automatic pulseStart(input bit expectAccept);
		@(posedge iClk);
		#DriveDelay;
		iCaptureStart_i = 1'b1;
		if (expectAccept) begin
			firstWin[acceptedCaptures] = cyc / GatePeriod;   // First wrap it can see.
			acceptedCaptures = acceptedCaptures + 1;
		end
		@(posedge iClk);
		#DriveDelay;
		iCaptureStart_i = 1'b0;
	endtask

	// Single-clock pulses, none near a window edge.
	task automatic drivePulses();
		int gap;
		int phase;
		forever begin
			gap = 2 + int'($unsigned($random(seed)) % 8);
			repeat (gap) @(posedge iClk);
			#DriveDelay;
			phase = (cyc + 3) % GatePeriod;                  // Counted three clocks later.
			if ((phase >= 3) && (phase <= GatePeriod - 4)) begin
				iPulse_i = 1'b1;
				winCount[(cyc + 3) / GatePeriod] = winCount[(cyc + 3) / GatePeriod] + 1;
				@(posedge iClk);
				#DriveDelay;
				iPulse_i = 1'b0;
			end
		end
	endtask

	// Quiet line until the first accepted strobe.
	assert property (@(posedge iClk) disable iff (!iRst_N)
		(acceptedCaptures == 0) |-> oTxd_o)
		else logMismatch("oTxd_o", 1, int'($sampled(oTxd_o)));
	assert property (@(posedge iClk) disable iff (!iRst_N)
		(acceptedCaptures == 0) |-> !oCaptureBusy_o)
		else logMismatch("oCaptureBusy_o", 0, int'($sampled(oCaptureBusy_o)));
	assert property (@(posedge iClk) disable iff (!iRst_N)
		(acceptedCaptures == 0) |-> !oUploadBusy_o)
		else logMismatch("oUploadBusy_o", 0, int'($sampled(oUploadBusy_o)));

	// Busy drops only once every byte is in.
	assert property (@(posedge iClk) disable iff (!iRst_N)
		$fell(oUploadBusy_o) |-> (rxTotal == acceptedCaptures * WordBytes))
		else logMismatch("rxTotal", acceptedCaptures * WordBytes, rxTotal);

	// Word check, low byte first.
	always @(posedge iClk) begin
		if (byteValid) begin
			byteIdx = rxTotal - (acceptedCaptures - 1) * WordBytes;
			if ((acceptedCaptures == 0) || (byteIdx >= WordBytes)) begin
				reportFault("byte received with no upload expected");
			end else if ((byteIdx % 2) == 0) begin
				lowByte <= rxByte;
			end else begin
				winIdx = firstWin[acceptedCaptures - 1] + byteIdx / 2;
				rxWord = {rxByte, lowByte};
				assert (rxWord == countT'(winCount[winIdx])) else
					logMismatch("rxWord", winCount[winIdx], int'(rxWord));
			end
			rxTotal <= rxTotal + 1;
		end
	end

	// Every capture needs an accepted strobe.
	always @(negedge iClk) begin
		capBusyQ <= oCaptureBusy_o;
		if (oCaptureBusy_o && !capBusyQ) begin
			assert (capturesSeen < acceptedCaptures) else
				reportFault("capture started without an accepted start strobe");
			capturesSeen <= capturesSeen + 1;
		end
	end

	always @(posedge iClk) begin
		if (iRst_N) begin
			cyc <= cyc + 1;
		end
		if (cyc >= TimeoutCycles) begin
			$display("Timeout after %0d cycles, uploads did not complete", cyc);
			$display("Errors: value %0d rule %0d framing %0d", valueErrors, ruleErrors,
				frameErrors);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		iRst_N          = 1'b0;
		iPulse_i        = 1'b0;
		iCaptureStart_i = 1'b0;
		seed            = 77;
		foreach (winCount[i]) begin
			winCount[i] = 0;
		end
		repeat (16) @(posedge iClk);
		#DriveDelay;
		iRst_N = 1'b1;
		fork
			drivePulses();
		join_none
		repeat (3 * GatePeriod) @(posedge iClk);        // Idle checks run here.
		pulseStart(1'b1);
		repeat (20 * GatePeriod) @(posedge iClk);
		pulseStart(1'b0);                               // Dropped, capture running.
		wait (oUploadBusy_o);
		repeat (50 * FrameBits * BaudDiv) @(posedge iClk);
		pulseStart(1'b0);                               // Dropped, upload running.
		wait (!oUploadBusy_o);
		repeat (4 * GatePeriod) @(posedge iClk);        // No restart, no stray bytes.
		pulseStart(1'b1);
		wait (oUploadBusy_o);
		wait (!oUploadBusy_o);
		repeat (2 * GatePeriod) @(posedge iClk);
		assert (capturesSeen == 2) else logMismatch("capturesSeen", 2, capturesSeen);
		assert (rxTotal == 2 * WordBytes) else logMismatch("rxTotal", 2 * WordBytes, rxTotal);
		$display("Errors: value %0d rule %0d framing %0d", valueErrors, ruleErrors,
			frameErrors);
		if ((valueErrors + ruleErrors + frameErrors) == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== tests/uartFrameMonitor.sv ====
`timescale 1ns/1ns

module uartFrameMonitor (
	input  logic                            iClk,
	input  logic                            iRst_N,
	input  logic                            iTxd_i,          // Line under test.
	output logic                            oByteValid_o,    // High for one clock per byte.
	output logic [uartDefsPkg::DataBits-1:0] oByte_o,        // Last decoded byte.
	output int                              oFrameErrors_o   // Bad start or stop bits.
);
	import uartDefsPkg::*;

	logic [DataBits-1:0] shiftIn;   // Bits collected LSB first.
	int                  bitIdx;

	// Samples on the falling clock, away from the line updates.
	initial begin
		oByteValid_o   = 1'b0;
		oByte_o        = '0;
		oFrameErrors_o = 0;
		shiftIn        = '0;
		forever begin
			@(negedge iClk);
			oByteValid_o = 1'b0;
			if (iRst_N && !iTxd_i) begin
				repeat (BaudDiv / 2 - 1) @(negedge iClk);   // Middle of the start bit.
				assert (iTxd_i == 1'b0) else begin
					oFrameErrors_o = oFrameErrors_o + 1;
					$display("ERR %0t oTxd_o start bit expected 0 actual %b", $time, iTxd_i);
				end
				for (bitIdx = 0; bitIdx < DataBits; bitIdx++) begin
					repeat (BaudDiv) @(negedge iClk);
					shiftIn = {iTxd_i, shiftIn[DataBits-1:1]};
				end
				repeat (BaudDiv) @(negedge iClk);            // Middle of the stop bit.
				assert (iTxd_i == 1'b1) else begin
					oFrameErrors_o = oFrameErrors_o + 1;
					$display("ERR %0t oTxd_o stop bit expected 1 actual %b", $time, iTxd_i);
				end
				oByte_o      = shiftIn;
				oByteValid_o = 1'b1;                        // Cleared on the next falling clock.
			end
		end
	end

endmodule

// ==== source/pulseCaptureTop.sv ====
`timescale 1ns/1ns

module pulseCaptureTop (
	input  logic iClk,
	input  logic iRst_N,
	input  logic iPulse_i,          // Asynchronous pulse level.
	input  logic iCaptureStart_i,   // One-cycle capture request.
	output logic oTxd_o,            // UART transmit line.
	output logic oCaptureBusy_o,
	output logic oUploadBusy_o
);
	import captureDefsPkg::*;

	logic     countStrobe;   // Window closed.
	countT    countValue;    // Its total.
	ramWriteT ramWrite;      // Sequencer to RAM.
	ramReadT  ramRead;       // Uploader to RAM.
	countT    readData;      // RAM to uploader.
	logic     uploadStart;
	logic     uploadBusy;

	pulseGateCounter pulseGateCounter_i (
		.iClk           (iClk),
		.iRst_N         (iRst_N),
		.iPulse_i       (iPulse_i),
		.oCountStrobe_o (countStrobe),
		.oCountValue_o  (countValue)
	);

	captureSequencer captureSequencer_i (
		.iClk            (iClk),
		.iRst_N          (iRst_N),
		.iCaptureStart_i (iCaptureStart_i),
		.iCountStrobe_i  (countStrobe),
		.iCountValue_i   (countValue),
		.iUploadBusy_i   (uploadBusy),
		.oRamWrite_o     (ramWrite),
		.oUploadStart_o  (uploadStart),
		.oCaptureBusy_o  (oCaptureBusy_o)
	);

	sampleRam sampleRam_i (
		.iClk        (iClk),
		.iRamWrite_i (ramWrite),
		.iRamRead_i  (ramRead),
		.oReadData_o (readData)
	);

	uartUploader uartUploader_i (
		.iClk           (iClk),
		.iRst_N         (iRst_N),
		.iUploadStart_i (uploadStart),
		.iReadData_i    (readData),
		.oRamRead_o     (ramRead),
		.oTxd_o         (oTxd_o),
		.oUploadBusy_o  (uploadBusy)
	);

	assign oUploadBusy_o = uploadBusy;    // Also gates new captures.

endmodule

// ==== source/uartUploader.sv ====
`timescale 1ns/1ns

module uartUploader (
	input  logic                    iClk,
	input  logic                    iRst_N,
	input  logic                    iUploadStart_i,  // One-cycle start.
	input  captureDefsPkg::countT   iReadData_i,     // RAM word, one clock late.
	output captureDefsPkg::ramReadT oRamRead_o,      // RAM read address.
	output logic                    oTxd_o,          // Serial line, idle high.
	output logic                    oUploadBusy_o    // Transfer in progress.
);
	import captureDefsPkg::*;
	import uartDefsPkg::*;

	typedef enum logic [1:0] {
		Idle,       // Line idle.
		Fetch,      // Address of the first word on the RAM.
		Load,       // First word valid.
		Send        // Shifting frames out.
	} upStateT;

	upStateT              state;
	addrT                 rdAddr;      // Word being read.
	logic [DataBits-1:0]  hiByte;      // Upper half of the current word.
	logic                 byteSel;     // High byte on the line.
	logic                 lastWord;    // Final word in flight.
	logic [FrameBits-1:0] shiftReg;    // Bit 0 drives the line.
	logic [BaudWidth-1:0] baudCnt;     // Clocks inside one bit.
	logic [BitWidth-1:0]  bitCnt;      // Bit inside one frame.
	logic                 bitEnd;
	logic                 frameEnd;
	logic                 loadLow;     // Start a new word.
	frameT                loFrame;
	frameT                hiFrame;

	assign bitEnd   = (baudCnt == BaudWidth'(BaudDiv - 1));
	assign frameEnd = bitEnd && (bitCnt == BitWidth'(FrameBits - 1));

	// First word, or the next one straight after a high byte.
	assign loadLow = (state == Load) ||
		((state == Send) && frameEnd && byteSel && !lastWord);

	always_comb begin
		loFrame.start = 1'b0;
		loFrame.data  = iReadData_i[DataBits-1:0];
		loFrame.stop  = 1'b1;
		hiFrame.start = 1'b0;
		hiFrame.data  = hiByte;
		hiFrame.stop  = 1'b1;
	end

	always_ff @(posedge iClk or negedge iRst_N) begin
		if (!iRst_N) begin
			state    <= Idle;
			rdAddr   <= '0;
			byteSel  <= 1'b0;
			lastWord <= 1'b0;
			shiftReg <= '1;                       // Line idles high.
			baudCnt  <= '0;
			bitCnt   <= '0;
		end else begin
			case (state)
				Idle: begin
					if (iUploadStart_i) begin
						rdAddr   <= '0;
						lastWord <= 1'b0;
						state    <= Fetch;
					end
				end
				Fetch: begin
					state <= Load;                    // RAM samples rdAddr.
				end
				Load: begin
					shiftReg <= loFrame;
					byteSel  <= 1'b0;
					baudCnt  <= '0;
					bitCnt   <= '0;
					state    <= Send;
				end
				Send: begin
					baudCnt <= bitEnd ? '0 : baudCnt + 1'b1;
					if (frameEnd) begin
						bitCnt <= '0;
						if (!byteSel) begin
							shiftReg <= hiFrame;         // High byte back to back.
							byteSel  <= 1'b1;
							// Prefetch the next word during the high byte.
							if (rdAddr == AddrWidth'(SampleDepth - 1)) begin
								lastWord <= 1'b1;
							end else begin
								rdAddr <= rdAddr + 1'b1;
							end
						end else if (lastWord) begin
							shiftReg <= '1;
							state    <= Idle;            // Busy drops here.
						end else begin
							shiftReg <= loFrame;
							byteSel  <= 1'b0;
						end
					end else if (bitEnd) begin
						bitCnt   <= bitCnt + 1'b1;
						shiftReg <= {1'b1, shiftReg[FrameBits-1:1]};
					end
				end
				default: begin
					state <= Idle;
				end
			endcase
		end
	end

	// Upper byte kept for the second frame.
	always_ff @(posedge iClk) begin
		if (loadLow) begin
			hiByte <= iReadData_i[CountWidth-1:DataBits];
		end
	end

	assign oRamRead_o.addr = rdAddr;
	assign oTxd_o          = shiftReg[0];
	assign oUploadBusy_o   = (state != Idle);

endmodule

// ==== source/sampleRam.sv ====
`timescale 1ns/1ns

module sampleRam (
	input  logic                     iClk,
	input  captureDefsPkg::ramWriteT iRamWrite_i,  // Write strobe, address, data.
	input  captureDefsPkg::ramReadT  iRamRead_i,   // Read address.
	output captureDefsPkg::countT    oReadData_o   // Data one clock later.
);
	import captureDefsPkg::*;

	countT mem [SampleDepth];                       // Block RAM array.

	// Write port.
	always_ff @(posedge iClk) begin
		if (iRamWrite_i.en) begin
			mem[iRamWrite_i.addr] <= iRamWrite_i.data;
		end
	end

	// Registered read port.
	always_ff @(posedge iClk) begin
		oReadData_o <= mem[iRamRead_i.addr];
	end

endmodule

// ==== source/captureSequencer.sv ====
`timescale 1ns/1ns

module captureSequencer (
	input  logic                     iClk,
	input  logic                     iRst_N,
	input  logic                     iCaptureStart_i,  // Start strobe.
	input  logic                     iCountStrobe_i,   // Window closed.
	input  captureDefsPkg::countT    iCountValue_i,    // Closed window total.
	input  logic                     iUploadBusy_i,    // Uploader still sending.
	output captureDefsPkg::ramWriteT oRamWrite_o,      // Sample RAM write port.
	output logic                     oUploadStart_o,   // Kicks the uploader.
	output logic                     oCaptureBusy_o    // Capture in progress.
);
	import captureDefsPkg::*;

	typedef enum logic [1:0] {
		Idle,       // Waiting for a start strobe.
		Wait,       // Waiting for the next window total.
		Write,      // One-cycle RAM write.
		Handoff     // Start the upload.
	} seqStateT;

	seqStateT state;
	addrT     wrAddr;       // Next RAM location.
	countT    countLatch;   // Total waiting to be written.
	logic     lastAddr;

	assign lastAddr = (wrAddr == AddrWidth'(SampleDepth - 1));

	always_ff @(posedge iClk or negedge iRst_N) begin
		if (!iRst_N) begin
			state  <= Idle;
			wrAddr <= '0;
		end else begin
			case (state)
				Idle: begin
					// Arm only while the line is free.
					if (iCaptureStart_i && !iUploadBusy_i) begin
						wrAddr <= '0;
						state  <= Wait;
					end
				end
				Wait: begin
					if (iCountStrobe_i) begin
						state <= Write;               // Count latched below.
					end
				end
				Write: begin
					if (lastAddr) begin
						state <= Handoff;             // RAM is full.
					end else begin
						wrAddr <= wrAddr + 1'b1;
						state  <= Wait;
					end
				end
				Handoff: begin
					state <= Idle;
				end
				default: begin
					state <= Idle;
				end
			endcase
		end
	end

	// First strobe seen in Wait.
	always_ff @(posedge iClk) begin
		if ((state == Wait) && iCountStrobe_i) begin
			countLatch <= iCountValue_i;
		end
	end

	always_comb begin
		oRamWrite_o.en   = (state == Write);        // Exactly one cycle.
		oRamWrite_o.addr = wrAddr;
		oRamWrite_o.data = countLatch;
	end

	assign oUploadStart_o = (state == Handoff);
	assign oCaptureBusy_o = (state != Idle);       // Wait through Handoff.

endmodule

// ==== source/pulseGateCounter.sv ====
`timescale 1ns/1ns

module pulseGateCounter (
	input  logic                  iClk,
	input  logic                  iRst_N,
	input  logic                  iPulse_i,        // Asynchronous pulse pin.
	output logic                  oCountStrobe_o,  // One cycle per window.
	output captureDefsPkg::countT oCountValue_o    // Total of the closed window.
);
	import captureDefsPkg::*;

	logic                 pulseSync1;   // First synchronizer stage.
	logic                 pulseSync2;   // Second synchronizer stage.
	logic                 pulseDly;     // Edge detector history.
	logic                 edgeSeen;
	logic [GateWidth-1:0] gateCnt;      // Free-running window position.
	logic                 gateWrap;
	countT                edgeAcc;      // Edges in the open window.
	countT                edgeNext;

	// Rising edge after the synchronizer.
	assign edgeSeen = pulseSync2 & ~pulseDly;

	// Last clock of the current window.
	assign gateWrap = (gateCnt == GateWidth'(GatePeriod - 1));

	// Accumulator holds at full scale.
	always_comb begin
		if (edgeAcc == '1) begin
			edgeNext = edgeAcc;
		end else begin
			edgeNext = edgeAcc + 1'b1;
		end
	end

	always_ff @(posedge iClk or negedge iRst_N) begin
		if (!iRst_N) begin
			pulseSync1     <= 1'b0;
			pulseSync2     <= 1'b0;
			pulseDly       <= 1'b0;
			gateCnt        <= '0;
			edgeAcc        <= '0;
			oCountStrobe_o <= 1'b0;
		end else begin
			pulseSync1     <= iPulse_i;
			pulseSync2     <= pulseSync1;
			pulseDly       <= pulseSync2;
			oCountStrobe_o <= gateWrap;           // Publish on the wrap.
			if (gateWrap) begin
				gateCnt <= '0;
				// Edge on the wrap clock opens the next window.
				edgeAcc <= edgeSeen ? countT'(1) : '0;
			end else begin
				gateCnt <= gateCnt + 1'b1;
				if (edgeSeen) begin
					edgeAcc <= edgeNext;
				end
			end
		end
	end

	// Window total, valid with the strobe.
	always_ff @(posedge iClk) begin
		if (gateWrap) begin
			oCountValue_o <= edgeAcc;
		end
	end

endmodule

// ==== source/uartDefsPkg.sv ====
package uartDefsPkg;

	localparam int BaudDiv   = 16;                    // Clocks per serial bit.
	localparam int BaudWidth = $clog2(BaudDiv);       // Bit timer width.

	localparam int DataBits  = 8;                     // Payload bits per frame.
	localparam int FrameBits = 10;                    // Start, data and stop.
	localparam int BitWidth  = $clog2(FrameBits);     // Bit index width.

	// One 8N1 character in wire order from bit 0 upward.
	typedef struct packed {
		logic                stop;                    // Always high.
		logic [DataBits-1:0] data;                    // Sent LSB first.
		logic                start;                   // Always low.
	} frameT;

endpackage

// ==== source/captureDefsPkg.sv ====
package captureDefsPkg;

	localparam int CountWidth  = 16;                  // Bits per window count.
	localparam int SampleDepth = 3000;                // Windows per capture.
	localparam int AddrWidth   = 12;                  // Sample RAM address bits.

	localparam int GatePeriod  = 64;                  // Clocks per counting window.
	localparam int GateWidth   = $clog2(GatePeriod);  // Window counter bits.

	typedef logic [CountWidth-1:0] countT;            // One window total.
	typedef logic [AddrWidth-1:0]  addrT;             // One RAM location.

	// Write side of the sample RAM.
	typedef struct packed {
		logic  en;                                    // Single-cycle write strobe.
		addrT  addr;                                  // Target word.
		countT data;                                  // Count to store.
	} ramWriteT;

	// Read side of the sample RAM.
	typedef struct packed {
		addrT addr;                                   // Word to fetch.
	} ramReadT;

endpackage
